//--- files.f
design/periph_pkg.sv
design/mem_if.sv
design/mem_interconnect.sv
design/scratch_ram.sv
design/qspi.sv
design/periph_top.sv
verif/qspi_device_model.sv
verif/periph_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module periph_tb \
  -f files.f -o periph_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/periph_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Regression passed$" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1

//--- verif/periph_tb.sv
`timescale 1ns/1ps

module periph_tb;
  import periph_pkg::*;

  localparam int ram_words = 64;
  localparam int timeout_cycles = 200;

  logic clock = 1'b0;
  logic reset;
  logic mem_valid;
  addr_t mem_addr;
  data_t mem_wdata;
  strobe_t mem_wstrb;
  data_t mem_rdata;
  logic mem_ready;
  logic mem_error;
  logic sclk;
  logic cs;
  logic read_mode;
  wire d0;
  wire d1;
  wire d2;
  wire d3;

  // outputs are sampled on the falling edge and checked on the rising edge.
  logic ready_s;
  logic error_s;
  logic cs_s;
  logic sclk_s;
  data_t rdata_s;

  // expectations for the request in flight.
  logic active;
  logic idle_check;
  logic check_data;
  logic check_latency;
  logic cs_low_expected;
  logic cs_high_expected;
  logic exp_error;
  data_t exp_rdata;
  int latency;
  int mismatch_count;
  int failure_count;
  data_t ram_ref [ram_words];

  periph_top #(
    .ram_words(ram_words),
    .clock_rate(8)
  ) dut (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .mem_error(mem_error),
    .sclk(sclk),
    .cs(cs),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

  qspi_device_model device (
    .clock(clock),
    .sclk(sclk),
    .cs(cs),
    .read_mode(read_mode),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

  initial begin
    forever #4 clock = ~clock;
  end

  always @(negedge clock) begin
    ready_s <= mem_ready;
    error_s <= mem_error;
    cs_s <= cs;
    sclk_s <= sclk;
    rdata_s <= mem_rdata;
  end

  assert property (@(posedge clock) idle_check |-> (!ready_s && !error_s && cs_s && !sclk_s))
    else begin
      mismatch_count++;
      $display("mismatch in reset: mem_ready %h mem_error %h cs %h sclk %h, expected 0 0 1 0",
               ready_s, error_s, cs_s, sclk_s);
    end

  assert property (@(posedge clock) (ready_s && active) |-> error_s == exp_error)
    else begin
      mismatch_count++;
      $display("mismatch mem_error: got %h, expected %h", error_s, exp_error);
    end

  assert property (@(posedge clock) (ready_s && check_data) |-> rdata_s == exp_rdata)
    else begin
      mismatch_count++;
      $display("mismatch mem_rdata: got %h, expected %h", rdata_s, exp_rdata);
    end

  assert property (@(posedge clock) (ready_s && check_latency) |-> latency == 2)
    else begin
      failure_count++;
      $display("request completed after %0d cycles instead of 2", latency);
    end

  assert property (@(posedge clock) !active |-> !ready_s)
    else begin
      failure_count++;
      $display("mem_ready pulsed with no request pending");
    end

  assert property (@(posedge clock) cs_low_expected |-> !cs_s)
    else begin
      failure_count++;
      $display("cs went high before the quad-spi transfer ended");
    end

  assert property (@(posedge clock) cs_high_expected |-> cs_s)
    else begin
      failure_count++;
      $display("cs still low after the quad-spi transfer ended");
    end

  task automatic issue(input addr_t addr, input data_t wdata, input strobe_t wstrb,
                       input logic fixed, input logic quad, input logic error_expected,
                       input logic data_known, input data_t data_expected);
    int count;
    logic done;
    count = 0;
    done = 1'b0;
    active = 1'b1;
    check_latency = fixed;
    exp_error = error_expected;
    check_data = data_known;
    exp_rdata = data_expected;
    mem_addr = addr;
    mem_wdata = wdata;
    mem_wstrb = wstrb;
    mem_valid = 1'b1;
    while (!done && count < timeout_cycles) begin
      @(negedge clock);
      count++;
      latency = count;
      cs_high_expected = 1'b0;
      // chip select falls one cycle after the interconnect strobes the port.
      cs_low_expected = quad && count >= 2;
      if (mem_ready) begin
        done = 1'b1;
        mem_valid = 1'b0;
      end
    end
    if (!done) begin
      failure_count++;
      $display("timeout: no mem_ready within %0d cycles for address %h", timeout_cycles, addr);
      mem_valid = 1'b0;
    end
    @(negedge clock);
    active = 1'b0;
    check_data = 1'b0;
    check_latency = 1'b0;
    cs_low_expected = 1'b0;
    cs_high_expected = quad;
  endtask

  task automatic write_ram(input int word, input data_t data, input strobe_t strobes);
    issue(addr_t'(word * 8), data, strobes, 1'b1, 1'b0, 1'b0, 1'b0, '0);
    for (int i = 0; i < 8; i++) begin
      if (strobes[i]) begin
        ram_ref[word][8*i +: 8] = data[8*i +: 8];
      end
    end
  endtask

  task automatic read_ram(input int word);
    issue(addr_t'(word * 8), '0, '0, 1'b1, 1'b0, 1'b0, 1'b1, ram_ref[word]);
  endtask

  task automatic write_qspi(input byte_t value);
    data_t wdata;
    wdata = {32'($urandom), 24'($urandom), value};
    issue(QSPI_ADDR, wdata, strobe_t'($urandom) | 8'h01, 1'b0, 1'b1, 1'b0, 1'b0, '0);
  endtask

  task automatic read_qspi(input byte_t value);
    read_mode = 1'b1;
    issue(QSPI_ADDR, '0, '0, 1'b0, 1'b1, 1'b0, 1'b1, data_t'(value));
    read_mode = 1'b0;
  endtask

  task automatic unmapped(input addr_t addr, input logic write);
    issue(addr, {$urandom, $urandom}, write ? 8'hff : 8'h00, 1'b1, 1'b0, 1'b1, 1'b1, '0);
  endtask

  initial begin
    int word;
    strobe_t strb;
    byte_t value;
    addr_t base;
    void'($urandom(81));
    reset = 1'b0;
    mem_valid = 1'b0;
    mem_addr = '0;
    mem_wdata = '0;
    mem_wstrb = '0;
    read_mode = 1'b0;
    ready_s = 1'b0;
    error_s = 1'b0;
    cs_s = 1'b1;
    sclk_s = 1'b0;
    rdata_s = '0;
    active = 1'b0;
    idle_check = 1'b0;
    check_data = 1'b0;
    check_latency = 1'b0;
    cs_low_expected = 1'b0;
    cs_high_expected = 1'b0;
    exp_error = 1'b0;
    exp_rdata = '0;
    latency = 0;
    mismatch_count = 0;
    failure_count = 0;
    repeat (5) begin
      @(negedge clock);
      idle_check = 1'b1;
    end
    reset = 1'b1;
    @(negedge clock);
    idle_check = 1'b0;
    for (int w = 0; w < ram_words; w++) begin
      write_ram(w, {$urandom, $urandom}, 8'hff);
    end
    repeat (48) begin
      word = $urandom % ram_words;
      strb = strobe_t'($urandom);
      if (strb == '0) begin
        strb = 8'h01;
      end
      write_ram(word, {$urandom, $urandom}, strb);
    end
    for (int w = 0; w < ram_words; w++) begin
      read_ram(w);
    end
    // ram access straight after each quad-spi transfer.
    repeat (8) begin
      value = byte_t'($urandom);
      write_qspi(value);
      read_ram($urandom % ram_words);
      read_qspi(value);
      read_ram($urandom % ram_words);
    end
    for (int i = 0; i < 6; i++) begin
      word = $urandom % ram_words;
      base = (i % 2 == 0) ? 32'h8000_0000 : 32'h0000_0200;
      unmapped(base + addr_t'(word * 8), 1'b1);
      unmapped(base + addr_t'(word * 8), 1'b0);
      read_ram(word);
    end
    repeat (4) @(negedge clock);
    $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
    if (mismatch_count == 0 && failure_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- verif/qspi_device_model.sv
`timescale 1ns/1ps

module qspi_device_model (
  input logic clock,
  input logic sclk,
  input logic cs,
  input logic read_mode,
  inout wire d0,
  inout wire d1,
  inout wire d2,
  inout wire d3
);
  import periph_pkg::*;

  logic sclk_prev;
  logic cs_prev;
  logic rose;
  logic [1:0] nibble_count;
  nibble_t sample;
  nibble_t high;
  byte_t last_byte;
  nibble_t out_nibble;

  // pins are oversampled on the falling system clock, where they are stable.
  always @(negedge clock) begin
    sclk_prev <= sclk;
    cs_prev <= cs;
    if (cs) begin
      rose <= 1'b0;
      nibble_count <= '0;
    end else if (!cs_prev) begin
      if (sclk && !sclk_prev) begin
        rose <= 1'b1;
        sample <= {d3, d2, d1, d0};
      end
      // a nibble ends on the falling sclk after its rising edge.
      if (!sclk && sclk_prev && rose) begin
        rose <= 1'b0;
        nibble_count <= nibble_count + 2'd1;
        if (!read_mode && nibble_count == 2'd0) begin
          high <= sample;
        end else if (!read_mode && nibble_count == 2'd1) begin
          last_byte <= {high, sample};
        end
      end
    end
  end

  // high nibble first on reads.
  assign out_nibble = (nibble_count == 2'd0) ? last_byte[7:4] : last_byte[3:0];

  assign d0 = (!cs && read_mode) ? out_nibble[0] : 1'bz;
  assign d1 = (!cs && read_mode) ? out_nibble[1] : 1'bz;
  assign d2 = (!cs && read_mode) ? out_nibble[2] : 1'bz;
  assign d3 = (!cs && read_mode) ? out_nibble[3] : 1'bz;

endmodule

//--- design/periph_top.sv
`timescale 1ns/1ps

module periph_top #(
  parameter int ram_words = 64,
  parameter int clock_rate = 8
) (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input periph_pkg::addr_t mem_addr,
  input periph_pkg::data_t mem_wdata,
  input periph_pkg::strobe_t mem_wstrb,
  output periph_pkg::data_t mem_rdata,
  output logic mem_ready,
  output logic mem_error,
  output logic sclk,
  output logic cs,
  inout wire d0,
  inout wire d1,
  inout wire d2,
  inout wire d3
);

  mem_if ram_bus ();
  mem_if qspi_bus ();

  mem_interconnect #(
    .ram_words(ram_words)
  ) decoder (
    .clock(clock),
    .reset(reset),
    .mem_valid(mem_valid),
    .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .mem_wstrb(mem_wstrb),
    .mem_rdata(mem_rdata),
    .mem_ready(mem_ready),
    .mem_error(mem_error),
    .ram_bus(ram_bus),
    .qspi_bus(qspi_bus)
  );

  scratch_ram #(
    .ram_words(ram_words)
  ) ram (
    .clock(clock),
    .reset(reset),
    .bus(ram_bus)
  );

  qspi #(
    .clock_rate(clock_rate)
  ) port (
    .clock(clock),
    .reset(reset),
    .bus(qspi_bus),
    .sclk(sclk),
    .cs(cs),
    .d0(d0),
    .d1(d1),
    .d2(d2),
    .d3(d3)
  );

endmodule

//--- design/qspi.sv
`timescale 1ns/1ps

module qspi #(
  parameter int clock_rate = 8
) (
  input logic clock,
  input logic reset,
  mem_if.target bus,
  output logic sclk,
  output logic cs,
  inout wire d0,
  inout wire d1,
  inout wire d2,
  inout wire d3
);
  import periph_pkg::*;

  localparam int half = clock_rate / 2;
  localparam int count_bits = $clog2(half);
  localparam logic [count_bits-1:0] last = count_bits'(half - 1);

  logic [count_bits-1:0] counter;
  logic sclk_q;
  logic cs_q;
  logic tick;
  logic rise;
  logic fall;
  logic rose;
  logic write_op;
  logic drive_en;
  qspi_state_t state;
  byte_t data;
  nibble_t nibble_in;
  nibble_t nibble_out;

  // serial clock edges, one clock ahead of the pin.
  assign tick = counter == last;
  assign rise = tick && !sclk_q;
  assign fall = tick && sclk_q;

  assign nibble_in = {d3, d2, d1, d0};

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      counter <= '0;
      sclk_q <= 1'b0;
      cs_q <= 1'b1;
      rose <= 1'b0;
      write_op <= 1'b0;
      state <= idle;
    end else begin
      if (tick) begin
        counter <= '0;
        sclk_q <= !sclk_q;
      end else begin
        counter <= counter + 1'b1;
      end
      case (state)
        idle: begin
          if (bus.valid) begin
            write_op <= |bus.wstrb;
            rose <= 1'b0;
            cs_q <= 1'b0;
            state <= high_nibble;
          end
        end
        high_nibble: begin
          // a nibble needs a rising edge before its falling edge counts.
          if (rise) begin
            rose <= 1'b1;
          end
          if (fall && rose) begin
            rose <= 1'b0;
            state <= low_nibble;
          end
        end
        low_nibble: begin
          if (rise) begin
            rose <= 1'b1;
          end
          if (fall && rose) begin
            rose <= 1'b0;
            state <= done;
          end
        end
        done: begin
          cs_q <= 1'b1;
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

  // shift byte, loaded on a write strobe, filled on read edges.
  always_ff @(posedge clock) begin
    if (state == idle && bus.valid && |bus.wstrb) begin
      data <= byte_t'(bus.wdata);
    end else if (!write_op && fall && rose) begin
      if (state == high_nibble) begin
        data[7:4] <= nibble_in;
      end else if (state == low_nibble) begin
        data[3:0] <= nibble_in;
      end
    end
  end

  assign drive_en = write_op && (state == high_nibble || state == low_nibble);
  assign nibble_out = (state == high_nibble) ? data[7:4] : data[3:0];

  assign d0 = drive_en ? nibble_out[0] : 1'bz;
  assign d1 = drive_en ? nibble_out[1] : 1'bz;
  assign d2 = drive_en ? nibble_out[2] : 1'bz;
  assign d3 = drive_en ? nibble_out[3] : 1'bz;

  assign sclk = sclk_q;
  assign cs = cs_q;

  assign bus.rdata = data_t'(data);
  assign bus.ready = state == done;
  assign bus.error = 1'b0;

  // chip select covers the whole transfer.
  assert property (@(posedge clock) disable iff (!reset)
    state != idle |-> !cs);

  // reads leave the lines to the device.
  assert property (@(posedge clock) disable iff (!reset)
    (state != idle && !write_op) |-> !drive_en);

endmodule

//--- design/scratch_ram.sv
`timescale 1ns/1ps

module scratch_ram #(
  parameter int ram_words = 64
) (
  input logic clock,
  input logic reset,
  mem_if.target bus
);
  import periph_pkg::*;

  localparam int strobe_bits = $bits(strobe_t);
  localparam int word_shift = $clog2(strobe_bits);
  localparam int index_bits = $clog2(ram_words);

  data_t mem [ram_words];
  data_t rdata;
  logic ready;
  logic [index_bits-1:0] index;

  // word index, byte offset dropped.
  assign index = bus.addr[word_shift +: index_bits];

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      ready <= 1'b0;
    end else begin
      ready <= bus.valid;
    end
  end

  always_ff @(posedge clock) begin
    if (bus.valid) begin
      for (int i = 0; i < strobe_bits; i++) begin
        if (bus.wstrb[i]) begin
          mem[index][8*i +: 8] <= bus.wdata[8*i +: 8];
        end
      end
      if (bus.wstrb == '0) begin
        rdata <= mem[index];
      end
    end
  end

  assign bus.rdata = rdata;
  assign bus.ready = ready;
  assign bus.error = 1'b0;

  // every answer belongs to the strobe one cycle earlier.
  assert property (@(posedge clock) disable iff (!reset)
    bus.ready |-> $past(bus.valid));

endmodule

//--- design/mem_interconnect.sv
`timescale 1ns/1ps

module mem_interconnect #(
  parameter int ram_words = 64
) (
  input logic clock,
  input logic reset,
  input logic mem_valid,
  input periph_pkg::addr_t mem_addr,
  input periph_pkg::data_t mem_wdata,
  input periph_pkg::strobe_t mem_wstrb,
  output periph_pkg::data_t mem_rdata,
  output logic mem_ready,
  output logic mem_error,
  mem_if.initiator ram_bus,
  mem_if.initiator qspi_bus
);
  import periph_pkg::*;

  localparam addr_t ram_bytes = addr_t'(ram_words * $bits(strobe_t));

  logic busy;
  logic issue;
  logic sel_ram;
  logic sel_qspi;
  logic none_ready;
  logic hit_ram;
  logic hit_qspi;
  addr_t req_addr;
  data_t req_wdata;
  strobe_t req_wstrb;

  // address decode on the incoming request.
  assign hit_ram = (mem_addr - RAM_BASE) < ram_bytes;
  assign hit_qspi = mem_addr == QSPI_ADDR;

  always_ff @(posedge clock) begin
    if (reset == 1'b0) begin
      busy <= 1'b0;
      issue <= 1'b0;
      sel_ram <= 1'b0;
      sel_qspi <= 1'b0;
      none_ready <= 1'b0;
    end else begin
      issue <= 1'b0;
      // unmapped requests are answered here, one cycle after the issue slot.
      none_ready <= issue && !sel_ram && !sel_qspi;
      if (!busy && mem_valid) begin
        busy <= 1'b1;
        issue <= 1'b1;
        sel_ram <= hit_ram;
        sel_qspi <= hit_qspi;
      end
      if (mem_ready) begin
        busy <= 1'b0;
      end
    end
  end

  // request payload.
  always_ff @(posedge clock) begin
    if (!busy && mem_valid) begin
      req_addr <= mem_addr;
      req_wdata <= mem_wdata;
      req_wstrb <= mem_wstrb;
    end
  end

  assign ram_bus.valid = issue && sel_ram;
  assign ram_bus.addr = req_addr - RAM_BASE;
  assign ram_bus.wdata = req_wdata;
  assign ram_bus.wstrb = req_wstrb;

  assign qspi_bus.valid = issue && sel_qspi;
  assign qspi_bus.addr = req_addr;
  assign qspi_bus.wdata = req_wdata;
  assign qspi_bus.wstrb = req_wstrb;

  // response mux, passed through in the target's ready cycle.
  assign mem_ready = (sel_ram && ram_bus.ready) || (sel_qspi && qspi_bus.ready) || none_ready;
  assign mem_error = (sel_ram && ram_bus.ready && ram_bus.error)
                  || (sel_qspi && qspi_bus.ready && qspi_bus.error)
                  || none_ready;

  always_comb begin
    mem_rdata = '0;
    if (sel_ram && ram_bus.ready) begin
      mem_rdata = ram_bus.rdata;
    end else if (sel_qspi && qspi_bus.ready) begin
      mem_rdata = qspi_bus.rdata;
    end
  end

  // only one target sees a strobe.
  assert property (@(posedge clock) disable iff (!reset)
    $onehot0({ram_bus.valid, qspi_bus.valid}));

endmodule

//--- design/mem_if.sv
`timescale 1ns/1ps

interface mem_if;
  import periph_pkg::*;

  // request side.
  logic valid;
  addr_t addr;
  data_t wdata;
  strobe_t wstrb;

  // response side, all valid in the ready cycle.
  data_t rdata;
  logic ready;
  logic error;

  modport initiator (
    output valid,
    output addr,
    output wdata,
    output wstrb,
    input rdata,
    input ready,
    input error
  );

  modport target (
    input valid,
    input addr,
    input wdata,
    input wstrb,
    output rdata,
    output ready,
    output error
  );

endinterface

//--- design/periph_pkg.sv
package periph_pkg;

  // bus widths.
  typedef logic [31:0] addr_t;
  typedef logic [63:0] data_t;
  typedef logic [7:0] strobe_t;

  // quad-spi payload and transfer unit.
  typedef logic [7:0] byte_t;
  typedef logic [3:0] nibble_t;

  // one byte moves as two nibbles, high first.
  typedef enum logic [1:0] {
    idle,
    high_nibble,
    low_nibble,
    done
  } qspi_state_t;

  // address map.
  localparam addr_t QSPI_ADDR = 32'h1000_0000;
  localparam addr_t RAM_BASE = 32'h0000_0000;

endpackage
